// ==== files.f ====
+incdir+src
src/ahbApbPkg.sv
src/apbBridgeFsm.sv
src/apbSlaveDecode.sv
src/apbTargetRegister.sv
src/apbTargetRam.sv
src/ahbApbBridge.sv
src/ahbApbSystem.sv
testbench/ahbApbTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module ahbApbTb \
  -f files.f -o ahbApbSim > "$LOG" 2>&1 &&
  ./obj_dir/ahbApbSim >> "$LOG" 2>&1 ||
  echo "Verification failed" >> "$LOG"
cat "$LOG"
grep -q "Verification failed" "$LOG" && exit 1 || exit 0

// ==== testbench/ahbApbTb.sv ====
// Testbench with clock, reset, AHB master stimulus, reference model and checking assertions
`include "ahbApb_defines.svh"

module ahbApbTb;
  timeunit 1ns;
  timeprecision 1ns;
  import ahbApbPkg::*;

  localparam int WAIT_LIMIT = 20;
  localparam int IDX_W      = $clog2(`RAM_DEPTH);

  logic   c;
  logic   HRESET;
  ahbReqT ahbReq;
  dataT   HWDATA;
  logic   HREADYIN;
  dataT   HRDATA;
  logic   HREADYOUT;
  apbReqT apbReq;

  int          errorCount;
  int          transferCount;
  int unsigned phase;       // Edges since acceptance, zero when idle
  logic        curWrite;
  addrT        curAddr;
  logic        isSetup;
  logic        isEnable;
  logic        expReady;
  pselT        expSel;
  dataT        expRead;
  dataT        refReg;
  dataT        refMem [0:`RAM_DEPTH-1];
  logic        accepted;

  assign HREADYIN = HREADYOUT;  // Single master, single bridge

  ahbApbSystem ahbApbSystem_inst (
    .c, .HRESET, .ahbReq, .HWDATA, .HREADYIN, .HRDATA, .HREADYOUT, .apbReq
  );

  initial
  begin
    c = 1'b0;
    forever #50 c = ~c;
  end

  assign accepted = ahbReq.hsel && HREADYIN &&
                    ((ahbReq.htrans == `HTRANS_NONSEQ) || (ahbReq.htrans == `HTRANS_SEQ));

  // Read takes setup then enable, write adds one wait cycle first
  assign isSetup  = (phase != 0) && (phase == (curWrite ? 2 : 1));
  assign isEnable = (phase != 0) && (phase == (curWrite ? 3 : 2));
  assign expReady = (phase == 0) || isEnable;

  always_ff @(posedge c)
  begin
    if (!HRESET)
      phase <= 0;
    else if (accepted)
    begin
      phase    <= 1;
      curWrite <= ahbReq.hwrite;
      curAddr  <= ahbReq.haddr;
    end
    else if (isEnable || (phase == 0))
      phase <= 0;
    else
      phase <= phase + 1;
  end

  // Reference targets follow each completed write
  always_ff @(posedge c)
  begin
    if (!HRESET)
      refReg <= '0;
    else if (isEnable && curWrite)
    begin
      if (curAddr[`REGION_MSB:`REGION_LSB] == regionT'(`REG_REGION))
        refReg <= HWDATA;
      else if (curAddr[`REGION_MSB:`REGION_LSB] == regionT'(`RAM_REGION))
        refMem[curAddr[`RAM_IDX_LSB +: IDX_W]] <= HWDATA;
    end
  end

  always_comb
  begin
    for (int i = 0; i < `APB_SLOTS; i++)
      expSel[i] = (curAddr[`REGION_MSB:`REGION_LSB] == regionT'(i));
    if (curAddr[`REGION_MSB:`REGION_LSB] == regionT'(`REG_REGION))
      expRead = refReg;
    else if (curAddr[`REGION_MSB:`REGION_LSB] == regionT'(`RAM_REGION))
      expRead = refMem[curAddr[`RAM_IDX_LSB +: IDX_W]];
    else
      expRead = '0;  // Unpopulated regions
  end

  task automatic reportMismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] got);
    errorCount++;
    $display("mismatch %s: expected %0h, got %0h", name, expected, got);
  endtask

  resetValues: assert property (@(posedge c)
    !HRESET |=> (HREADYOUT && (apbReq.psel == '0) && !apbReq.penable && !apbReq.pwrite)
  ) else reportMismatch("{HREADYOUT,psel,penable,pwrite}", {1'b1, 18'h0},
    $sampled({HREADYOUT, apbReq.psel, apbReq.penable, apbReq.pwrite}));

  setupSel: assert property (@(posedge c) disable iff (!HRESET)
    isSetup |-> (apbReq.psel == expSel)
  ) else reportMismatch("psel", $sampled(expSel), $sampled(apbReq.psel));

  setupAddr: assert property (@(posedge c) disable iff (!HRESET)
    isSetup |-> (apbReq.paddr == curAddr)
  ) else reportMismatch("paddr", $sampled(curAddr), $sampled(apbReq.paddr));

  setupDir: assert property (@(posedge c) disable iff (!HRESET)
    isSetup |-> ((apbReq.pwrite == curWrite) && !apbReq.penable)
  ) else reportMismatch("{pwrite,penable}", {$sampled(curWrite), 1'b0},
    $sampled({apbReq.pwrite, apbReq.penable}));

  // Request must be held unchanged from setup into enable
  enableHold: assert property (@(posedge c) disable iff (!HRESET)
    isEnable |-> ($stable(apbReq.psel) && $stable(apbReq.paddr) &&
                  $stable(apbReq.pwrite) && apbReq.penable)
  ) else
  begin
    errorCount++;
    $display("APB request changed or penable low in the enable cycle");
  end

  readyLevel: assert property (@(posedge c) disable iff (!HRESET)
    HREADYOUT == expReady
  ) else reportMismatch("HREADYOUT", $sampled(expReady), $sampled(HREADYOUT));

  writeData: assert property (@(posedge c) disable iff (!HRESET)
    (isEnable && curWrite) |-> (apbReq.pwdata == HWDATA)
  ) else reportMismatch("pwdata", $sampled(HWDATA), $sampled(apbReq.pwdata));

  readData: assert property (@(posedge c) disable iff (!HRESET)
    (isEnable && !curWrite) |-> (HRDATA == expRead)
  ) else reportMismatch("HRDATA", $sampled(expRead), $sampled(HRDATA));

  task automatic abortRun(input string reason);
    $display("Timeout, %s", reason);
    $display("Closing with %0d errors after %0d transfers", errorCount, transferCount);
    $display("Verification failed");
    $finish;
  endtask

  task automatic awaitReady(input string what);
    int cycles;
    cycles = 0;
    while (!HREADYOUT && (cycles < WAIT_LIMIT))
    begin
      @(negedge c);
      cycles++;
    end
    if (!HREADYOUT)
      abortRun(what);
  endtask

  function automatic addrT makeAddr(input int region, input int idx);
    addrT addr;
    addr = $urandom;
    addr[`REGION_MSB:`REGION_LSB] = regionT'(region);
    addr[`RAM_IDX_LSB +: IDX_W]   = IDX_W'(idx);
    return addr;
  endfunction

  // Called on a falling edge with HREADYOUT high, returns in the enable cycle
  task automatic doTransfer(input logic write, input addrT addr, input dataT data);
    ahbReq.haddr  = addr;
    ahbReq.hwrite = write;
    ahbReq.hsel   = 1'b1;
    ahbReq.htrans = $urandom_range(1) ? `HTRANS_SEQ : `HTRANS_NONSEQ;
    awaitReady("bridge not ready for the address phase");
    @(negedge c);
    ahbReq.hsel   = 1'b0;
    ahbReq.htrans = 2'b00;
    if (write)
      HWDATA = data;  // Held until the enable cycle ends
    transferCount++;
    awaitReady("transfer never reached its enable phase");
  endtask

  initial
  begin
    int idx;
    errorCount    = 0;
    transferCount = 0;
    void'($urandom(32'hb4d12f54));
    HRESET        = 1'b0;
    ahbReq        = '0;
    HWDATA        = '0;
    repeat (5) @(negedge c);
    HRESET = 1'b1;
    for (idx = 0; idx < `RAM_DEPTH; idx++)
      doTransfer(1'b1, makeAddr(`RAM_REGION, idx), $urandom);  // Known content everywhere
    doTransfer(1'b1, makeAddr(`REG_REGION, 0), $urandom);
    doTransfer(1'b0, makeAddr(`REG_REGION, 0), '0);
    for (int n = 0; n < 60; n++)
    begin
      idx = $urandom_range(`RAM_DEPTH - 1);
      doTransfer(1'($urandom_range(1)), makeAddr(`RAM_REGION, idx), $urandom);
      if ($urandom_range(3) == 0)
        @(negedge c);  // Idle gap
    end
    for (int r = 2; r < `APB_SLOTS; r++)
      doTransfer(1'b0, makeAddr(r, $urandom_range(`RAM_DEPTH - 1)), '0);
    @(negedge c);
    @(negedge c);
    $display("Closing with %0d errors after %0d transfers", errorCount, transferCount);
    if (errorCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== src/ahbApbSystem.sv ====
// Top level with the AHB-to-APB bridge, register target and RAM target
`include "ahbApb_defines.svh"

module ahbApbSystem (
  input  logic              c,
  input  logic              HRESET,
  input  ahbApbPkg::ahbReqT ahbReq,
  input  ahbApbPkg::dataT   HWDATA,
  input  logic              HREADYIN,
  output ahbApbPkg::dataT   HRDATA,
  output logic              HREADYOUT,
  output ahbApbPkg::apbReqT apbReq
);
  import ahbApbPkg::*;

  // Read data of the populated slots
  dataT prdata [0:`APB_TARGETS-1];

  ahbApbBridge bridge (
    .c,
    .HRESET,
    .ahbReq,
    .HWDATA,
    .HREADYIN,
    .prdata,
    .HRDATA,
    .HREADYOUT,
    .apbReq
  );

  apbTargetRegister regTarget (
    .c,
    .HRESET,
    .apbReq,
    .prdata (prdata[`REG_REGION])
  );

  apbTargetRam ramTarget (
    .c,
    .apbReq,
    .prdata (prdata[`RAM_REGION])
  );

endmodule

// ==== src/ahbApbBridge.sv ====
// AHB-to-APB bridge with address capture, APB outputs and read data return
`include "ahbApb_defines.svh"

module ahbApbBridge (
  input  logic              c,
  input  logic              HRESET,
  input  ahbApbPkg::ahbReqT ahbReq,
  input  ahbApbPkg::dataT   HWDATA,
  input  logic              HREADYIN,
  input  ahbApbPkg::dataT   prdata [0:`APB_TARGETS-1],
  output ahbApbPkg::dataT   HRDATA,
  output logic              HREADYOUT,
  output ahbApbPkg::apbReqT apbReq
);
  import ahbApbPkg::*;

  logic        accept;
  logic        setup;
  logic        hwriteQ;
  logic        pwrite;
  logic        penable;
  addrT        haddrQ;
  addrT        setupAddr;
  addrT        paddrQ;
  dataT        pwdataQ;
  dataT        rdSel;
  pselT        psel;
  bridgeStateT nextState;

  // Valid transfer request
  assign accept = ahbReq.hsel && HREADYIN &&
                  ((ahbReq.htrans == `HTRANS_NONSEQ) || (ahbReq.htrans == `HTRANS_SEQ));

  // Address phase capture
  always_ff @(posedge c)
  begin
    if (ahbReq.hsel && HREADYIN)
    begin
      haddrQ  <= ahbReq.haddr;
      hwriteQ <= ahbReq.hwrite;
    end
  end

  // Reads go straight to setup on the live address
  assign setupAddr = (nextState == READ) ? ahbReq.haddr : haddrQ;

  apbBridgeFsm fsm (
    .c,
    .HRESET,
    .accept,
    .hwrite    (ahbReq.hwrite),
    .nextState,
    .setup,
    .pwrite,
    .penable,
    .HREADYOUT
  );

  apbSlaveDecode decode (
    .c,
    .HRESET,
    .addr      (setupAddr),
    .nextState,
    .psel
  );

  always_ff @(posedge c)
  begin
    if (setup)
      paddrQ <= setupAddr;
    if (nextState == WRITEOK)
      pwdataQ <= HWDATA;   // HWDATA valid by the end of the wait cycle
  end

  // Read data of the selected slot, zero for empty regions
  always_comb
  begin
    rdSel = '0;
    for (int i = 0; i < `APB_TARGETS; i++)
    begin
      if (psel[i])
        rdSel = prdata[i];
    end
  end

  always_ff @(posedge c)
  begin
    if (nextState == READOK)
      HRDATA <= rdSel;
  end

  assign apbReq = '{psel: psel, paddr: paddrQ, pwrite: pwrite,
                    penable: penable, pwdata: pwdataQ};

  // AHB stalls for the whole setup phase
  setupStalls: assert property (
    @(posedge c) disable iff (!HRESET)
    ((|psel) && !penable) |-> !HREADYOUT
  );

  // Direction on APB matches the accepted transfer
  pwriteMatches: assert property (
    @(posedge c) disable iff (!HRESET)
    (|psel) |-> (pwrite == hwriteQ)
  );

endmodule

// ==== src/apbTargetRam.sv ====
// 32-word APB RAM target with combinational read
`include "ahbApb_defines.svh"

module apbTargetRam (
  input  logic              c,
  input  ahbApbPkg::apbReqT apbReq,
  output ahbApbPkg::dataT   prdata
);
  import ahbApbPkg::*;

  localparam int IDX_W = $clog2(`RAM_DEPTH);

  dataT             mem [0:`RAM_DEPTH-1];
  logic [IDX_W-1:0] idx;
  logic             wrEn;

  // Word index from the address bits under the region field
  assign idx  = apbReq.paddr[`RAM_IDX_LSB +: IDX_W];
  assign wrEn = apbReq.psel[`RAM_REGION] && apbReq.penable && apbReq.pwrite;

  always_ff @(posedge c)
  begin
    if (wrEn)
      mem[idx] <= apbReq.pwdata;
  end

  assign prdata = mem[idx];

endmodule

// ==== src/apbTargetRegister.sv ====
// Single 32-bit APB register target
`include "ahbApb_defines.svh"

module apbTargetRegister (
  input  logic              c,
  input  logic              HRESET,
  input  ahbApbPkg::apbReqT apbReq,
  output ahbApbPkg::dataT   prdata
);
  import ahbApbPkg::*;

  dataT content;
  logic wrEn;

  // Write on the enable edge of a selected access
  assign wrEn = apbReq.psel[`REG_REGION] && apbReq.penable && apbReq.pwrite;

  always_ff @(posedge c)
  begin
    if (!HRESET)
      content <= '0;
    else if (wrEn)
      content <= apbReq.pwdata;
  end

  assign prdata = content;  // Zero-cycle read

endmodule

// ==== src/apbSlaveDecode.sv ====
// Region decode of the APB address into registered one-hot peripheral selects
`include "ahbApb_defines.svh"

module apbSlaveDecode (
  input  logic                   c,
  input  logic                   HRESET,
  input  ahbApbPkg::addrT        addr,
  input  ahbApbPkg::bridgeStateT nextState,
  output ahbApbPkg::pselT        psel
);
  import ahbApbPkg::*;

  regionT region;
  pselT   pselDec;

  assign region  = addr[`REGION_MSB:`REGION_LSB];
  assign pselDec = pselT'(1) << region;  // One bit per region

  // Load on setup, drop when no access follows, hold through enable
  always_ff @(posedge c)
  begin
    if (!HRESET)
      psel <= '0;
    else if ((nextState == READ) || (nextState == WRITE))
      psel <= pselDec;
    else if ((nextState == IDLE) || (nextState == WWRITE))
      psel <= '0;
  end

  // At most one target selected
  pselOneHot: assert property (
    @(posedge c) disable iff (!HRESET)
    $onehot0(psel)
  );

endmodule

// ==== src/apbBridgeFsm.sv ====
// Bridge FSM with setup flag and registered PWRITE, PENABLE and HREADYOUT
module apbBridgeFsm (
  input  logic                   c,
  input  logic                   HRESET,
  input  logic                   accept,
  input  logic                   hwrite,
  output ahbApbPkg::bridgeStateT nextState,
  output logic                   setup,
  output logic                   pwrite,
  output logic                   penable,
  output logic                   HREADYOUT
);
  import ahbApbPkg::*;

  bridgeStateT state;

  // Next state from current state and acceptance
  always_comb
  begin
    nextState = IDLE;
    case (state)
      IDLE, READOK, WRITEOK:
      begin
        // Enable cycles are also open for a new transfer
        if (accept)
          nextState = hwrite ? WWRITE : READ;
        else
          nextState = IDLE;
      end
      READ:
        nextState = READOK;
      WWRITE:
        nextState = WRITE;   // Write data arrives one cycle late
      WRITE:
        nextState = WRITEOK;
      default:
        nextState = IDLE;
    endcase
  end

  // Setup states load address and selects
  assign setup = (nextState == READ) || (nextState == WRITE);

  always_ff @(posedge c)
  begin
    if (!HRESET)
    begin
      state     <= IDLE;
      pwrite    <= 1'b0;
      penable   <= 1'b0;
      HREADYOUT <= 1'b1;
    end
    else
    begin
      state     <= nextState;
      pwrite    <= (nextState == WRITE) || (nextState == WRITEOK);
      penable   <= (nextState == READOK) || (nextState == WRITEOK);
      // Ready again once the access reaches its enable phase
      HREADYOUT <= (nextState == IDLE) || (nextState == READOK) ||
                   (nextState == WRITEOK);
    end
  end

  // Enable phase always directly follows a setup phase
  penableAfterSetup: assert property (
    @(posedge c) disable iff (!HRESET)
    penable |-> $past((state == READ) || (state == WRITE))
  );

endmodule

// ==== src/ahbApbPkg.sv ====
// Vector typedefs, bridge state enum and the AHB and APB request structs
`include "ahbApb_defines.svh"

package ahbApbPkg;

  typedef logic [`ADDR_W-1:0]                addrT;
  typedef logic [`DATA_W-1:0]                dataT;
  typedef logic [`APB_SLOTS-1:0]             pselT;    // One-hot peripheral selects
  typedef logic [`REGION_MSB-`REGION_LSB:0]  regionT;
  typedef logic [1:0]                        htransT;

  // Transfer sequence of the bridge
  typedef enum logic [2:0] {
    IDLE    = 3'b000,
    READ    = 3'b001,  // Read setup
    READOK  = 3'b101,  // Read enable
    WWRITE  = 3'b010,  // Wait for write data
    WRITE   = 3'b011,  // Write setup
    WRITEOK = 3'b110   // Write enable
  } bridgeStateT;

  // AHB address phase
  typedef struct packed {
    addrT   haddr;
    htransT htrans;
    logic   hwrite;
    logic   hsel;
  } ahbReqT;

  // APB request as seen by every target
  typedef struct packed {
    pselT   psel;
    addrT   paddr;
    logic   pwrite;
    logic   penable;
    dataT   pwdata;
  } apbReqT;

endpackage

// ==== src/ahbApb_defines.svh ====
// Bus widths, region decode field, RAM geometry, target regions and HTRANS codes
`ifndef AHBAPB_DEFINES_SVH
`define AHBAPB_DEFINES_SVH

// Bus widths
`define ADDR_W        32
`define DATA_W        32

// One select per 256 MB region
`define APB_SLOTS     16
`define REGION_MSB    31
`define REGION_LSB    28

// RAM target geometry
`define RAM_DEPTH     32
`define RAM_IDX_LSB   23  // Word index sits just below the region field

// Populated regions
`define REG_REGION    0
`define RAM_REGION    1
`define APB_TARGETS   2

// Accepted transfer types
`define HTRANS_NONSEQ 2'b10
`define HTRANS_SEQ    2'b11

`endif
